//--- include/ooo_config.svh
// index widths in ooo_pkg are fixed for these sizes and must change together with them
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

////////////////////////////////////////////////////
// register files

`define OOO_ARF_SIZE   32 // architectural registers
`define OOO_PRF_SIZE   64 // physical registers, upper half starts free
`define OOO_ZERO_REG   31 // always reads zero, writes are dropped

////////////////////////////////////////////////////
// window and pipeline

`define OOO_ROB_SIZE   16 // power of two, pointers wrap
`define OOO_RS_SIZE    8  // reservation station slots
`define OOO_MUL_STAGES 3  // two or more, first two do the arithmetic

`endif

//--- verilog/ooo_pkg.sv
// single thread core types; opcode values are local to this core and not a real ISA
`default_nettype none

package ooo_pkg;

	typedef logic [4:0]  arn_t;     // architectural register number
	typedef logic [5:0]  prn_t;     // physical register number
	typedef logic [3:0]  rob_idx_t; // reorder buffer slot
	typedef logic [63:0] value_t;   // data word

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0, // also used for addi
		ALU_SUB = 2'd1,
		ALU_MUL = 2'd2  // low 64 bits only
	} fu_func_t;

	typedef struct packed {
		logic [5:0]  opcode;
		arn_t        dest;
		arn_t        srca;
		arn_t        srcb;
		logic [10:0] unused; // ignored
	} reg_fmt_t;

	// opcode, dest and srca sit where reg_fmt_t has them
	typedef struct packed {
		logic [5:0]  opcode;
		arn_t        dest;
		arn_t        srca;
		logic [15:0] imm;    // signed
	} imm_fmt_t;

	typedef union packed {
		reg_fmt_t r;
		imm_fmt_t i;
	} inst_word_u;

	localparam logic [5:0] OP_ADD  = 6'h10;
	localparam logic [5:0] OP_SUB  = 6'h11;
	localparam logic [5:0] OP_MUL  = 6'h13;
	localparam logic [5:0] OP_ADDI = 6'h08;

endpackage

`default_nettype wire

//--- verilog/ooo_if.sv
// plain wires with no handshake; every valid here is a single cycle strobe
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

// common data bus, one result per cycle
interface cdb_if;
	logic              valid;
	ooo_pkg::prn_t     tag;     // destination physical register
	ooo_pkg::value_t   value;
	ooo_pkg::rob_idx_t rob_idx; // slot to mark done
	modport source   (output valid, tag, value, rob_idx);
	modport listener (input valid, tag, value, rob_idx);
endinterface

interface dispatch_if;
	logic              valid;     // already qualified by stall
	ooo_pkg::fu_func_t func;
	ooo_pkg::value_t   opa;
	ooo_pkg::value_t   opb;
	logic              opa_ready; // value is final, tag unused
	logic              opb_ready;
	ooo_pkg::prn_t     opa_tag;
	ooo_pkg::prn_t     opb_tag;
	ooo_pkg::prn_t     dest;
	ooo_pkg::rob_idx_t rob_idx;
	logic              full;      // back from the reservation station
	modport source (output valid, func, opa, opb, opa_ready, opb_ready, opa_tag, opb_tag,
		dest, rob_idx, input full);
	modport sink (input valid, func, opa, opb, opa_ready, opb_ready, opa_tag, opb_tag,
		dest, rob_idx, output full);
endinterface

interface rob_alloc_if;
	logic              valid;
	ooo_pkg::arn_t     arn;
	logic              has_dest; // low for the zero register
	ooo_pkg::prn_t     new_prn;
	ooo_pkg::prn_t     old_prn;  // freed when this entry commits
	ooo_pkg::rob_idx_t tail_idx;
	logic              full;
	modport source (output valid, arn, has_dest, new_prn, old_prn, input tail_idx, full);
	modport sink   (input valid, arn, has_dest, new_prn, old_prn, output tail_idx, full);
endinterface

`default_nettype wire

//--- verilog/rename_stage.sv
// one instruction per cycle; unknown opcodes are taken and dropped without reaching the ROB
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module rename_stage (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                inst_valid, // held by the source while stall is high
	input  ooo_pkg::inst_word_u inst,
	output logic                stall,
	cdb_if.listener             cdb,
	dispatch_if.source          disp,
	rob_alloc_if.source         alloc,
	input  logic                free_valid, // old register back from commit
	input  ooo_pkg::prn_t       free_prn
);
	localparam int FL_DEPTH = `OOO_PRF_SIZE - `OOO_ARF_SIZE;
	localparam int FL_W     = $clog2(FL_DEPTH);
	localparam ooo_pkg::prn_t ZERO_PRN = ooo_pkg::prn_t'(`OOO_ZERO_REG); // never remapped

	ooo_pkg::prn_t            rat [`OOO_ARF_SIZE];  // alias table
	ooo_pkg::value_t          prf [`OOO_PRF_SIZE];
	logic [`OOO_PRF_SIZE-1:0] prf_ready;
	ooo_pkg::prn_t            free_list [FL_DEPTH]; // circular, pop at head
	logic [FL_W-1:0]          fl_head;
	logic [FL_W-1:0]          fl_tail;
	logic [FL_W:0]            fl_count;

	logic [5:0]      opcode;
	logic            is_reg;
	logic            is_imm;
	logic            need_dest;
	logic            dispatch;
	logic            fl_pop;
	ooo_pkg::prn_t   opa_tag;
	ooo_pkg::prn_t   opb_tag;
	ooo_pkg::value_t imm_ext;

	//////////////////////////////////////////////////
	// decode, both formats share opcode/dest/srca

	assign opcode    = inst.r.opcode;
	assign is_reg    = (opcode == ooo_pkg::OP_ADD) || (opcode == ooo_pkg::OP_SUB) ||
		(opcode == ooo_pkg::OP_MUL);
	assign is_imm    = opcode == ooo_pkg::OP_ADDI;
	assign imm_ext   = {{48{inst.i.imm[15]}}, inst.i.imm}; // sign extend
	assign need_dest = inst_valid && (is_reg || is_imm) &&
		(inst.r.dest != ooo_pkg::arn_t'(`OOO_ZERO_REG));

	assign stall    = disp.full || alloc.full || (need_dest && fl_count == '0);
	assign dispatch = inst_valid && !stall && (is_reg || is_imm);
	assign fl_pop   = dispatch && need_dest;

	always_comb begin
		case (opcode)
			ooo_pkg::OP_SUB: disp.func = ooo_pkg::ALU_SUB;
			ooo_pkg::OP_MUL: disp.func = ooo_pkg::ALU_MUL;
			default:         disp.func = ooo_pkg::ALU_ADD; // add and addi
		endcase
	end

	//////////////////////////////////////////////////
	// operand read with same cycle bus bypass

	assign opa_tag        = rat[inst.r.srca];
	assign opb_tag        = rat[inst.r.srcb]; // garbage for addi, ready hides it
	assign disp.opa_tag   = opa_tag;
	assign disp.opb_tag   = opb_tag;
	assign disp.opa_ready = prf_ready[opa_tag] || (cdb.valid && cdb.tag == opa_tag);
	assign disp.opb_ready = is_imm || prf_ready[opb_tag] || (cdb.valid && cdb.tag == opb_tag);
	assign disp.opa       = prf_ready[opa_tag] ? prf[opa_tag] : cdb.value;
	assign disp.opb       = is_imm ? imm_ext : (prf_ready[opb_tag] ? prf[opb_tag] : cdb.value);

	assign disp.valid   = dispatch;
	assign disp.dest    = need_dest ? alloc.new_prn : ZERO_PRN; // zero reg result is dropped
	assign disp.rob_idx = alloc.tail_idx;

	assign alloc.valid    = dispatch;
	assign alloc.arn      = inst.r.dest;
	assign alloc.has_dest = need_dest;
	assign alloc.new_prn  = free_list[fl_head];
	assign alloc.old_prn  = rat[inst.r.dest];

	//////////////////////////////////////////////////
	// alias table, register file and free list

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `OOO_ARF_SIZE; i++) begin
				rat[i] <= ooo_pkg::prn_t'(i); // identity map
			end
			for (int i = 0; i < `OOO_PRF_SIZE; i++) begin
				prf[i] <= '0;
			end
			for (int i = 0; i < FL_DEPTH; i++) begin
				free_list[i] <= ooo_pkg::prn_t'(`OOO_ARF_SIZE + i); // upper half free
			end
			prf_ready <= '1;
			fl_head   <= '0;
			fl_tail   <= '0;
			fl_count  <= (FL_W+1)'(FL_DEPTH);
		end else begin
			if (cdb.valid && cdb.tag != ZERO_PRN) begin
				prf[cdb.tag]       <= cdb.value;
				prf_ready[cdb.tag] <= 1'b1;
			end
			if (fl_pop) begin
				rat[inst.r.dest]         <= alloc.new_prn;
				prf_ready[alloc.new_prn] <= 1'b0; // waits for its producer
				fl_head                  <= fl_head + FL_W'(1);
			end
			if (free_valid) begin
				free_list[fl_tail] <= free_prn;
				fl_tail            <= fl_tail + FL_W'(1);
			end
			fl_count <= fl_count + (FL_W+1)'(free_valid) - (FL_W+1)'(fl_pop);
		end
	end

endmodule

`default_nettype wire

//--- verilog/issue_queue.sv
// issues at most one entry per cycle; a multiply is never blocked by the multiplier
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module issue_queue (
	input  logic              clock,
	input  logic              rst_n,
	dispatch_if.sink          disp,
	cdb_if.listener           cdb,
	input  logic              add_busy,   // adder still holds a result
	output logic              add_issue,
	output logic              mul_issue,
	output ooo_pkg::fu_func_t issue_func,
	output ooo_pkg::value_t   issue_opa,
	output ooo_pkg::value_t   issue_opb,
	output ooo_pkg::prn_t     issue_dest,
	output ooo_pkg::rob_idx_t issue_rob_idx
);
	localparam int N  = `OOO_RS_SIZE;
	localparam int IW = $clog2(N);

	logic [N-1:0]      valid;
	ooo_pkg::fu_func_t func    [N];
	ooo_pkg::value_t   opa     [N];
	ooo_pkg::value_t   opb     [N];
	logic [N-1:0]      opa_rdy;
	logic [N-1:0]      opb_rdy;
	ooo_pkg::prn_t     opa_tag [N];
	ooo_pkg::prn_t     opb_tag [N];
	ooo_pkg::prn_t     dest    [N];
	ooo_pkg::rob_idx_t rob_idx [N];
	logic [N-1:0]      older   [N]; // older[i][j] when i came in before j

	logic [N-1:0]  cand;
	logic [IW-1:0] free_idx;
	logic [IW-1:0] sel_idx;
	logic          sel_found;

	//////////////////////////////////////////////////
	// slot and issue select

	always_comb begin
		free_idx = '0;
		for (int i = N-1; i >= 0; i--) begin
			if (!valid[i])
				free_idx = IW'(i); // lowest empty slot
		end
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			cand[i] = valid[i] && opa_rdy[i] && opb_rdy[i] &&
				(func[i] == ooo_pkg::ALU_MUL || !add_busy);
		end
	end

	// one pick over both units, so the adder only wins when it is older
	always_comb begin : pick_oldest
		logic is_oldest;
		sel_idx   = '0;
		sel_found = 1'b0;
		for (int i = 0; i < N; i++) begin
			is_oldest = cand[i];
			for (int j = 0; j < N; j++) begin
				if (cand[j] && older[j][i])
					is_oldest = 1'b0;
			end
			if (is_oldest) begin
				sel_idx   = IW'(i);
				sel_found = 1'b1;
			end
		end
	end

	assign add_issue     = sel_found && func[sel_idx] != ooo_pkg::ALU_MUL;
	assign mul_issue     = sel_found && func[sel_idx] == ooo_pkg::ALU_MUL;
	assign issue_func    = func[sel_idx];
	assign issue_opa     = opa[sel_idx];
	assign issue_opb     = opb[sel_idx];
	assign issue_dest    = dest[sel_idx];
	assign issue_rob_idx = rob_idx[sel_idx];
	assign disp.full     = &valid;

	//////////////////////////////////////////////////
	// entry state

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			if (sel_found)
				valid[sel_idx] <= 1'b0;
			for (int i = 0; i < N; i++) begin
				if (cdb.valid && !opa_rdy[i] && cdb.tag == opa_tag[i]) begin
					opa[i]     <= cdb.value; // tag match wakes the operand
					opa_rdy[i] <= 1'b1;
				end
				if (cdb.valid && !opb_rdy[i] && cdb.tag == opb_tag[i]) begin
					opb[i]     <= cdb.value;
					opb_rdy[i] <= 1'b1;
				end
			end
			if (disp.valid) begin
				valid[free_idx]   <= 1'b1;
				func[free_idx]    <= disp.func;
				opa[free_idx]     <= disp.opa;
				opb[free_idx]     <= disp.opb;
				opa_rdy[free_idx] <= disp.opa_ready;
				opb_rdy[free_idx] <= disp.opb_ready;
				opa_tag[free_idx] <= disp.opa_tag;
				opb_tag[free_idx] <= disp.opb_tag;
				dest[free_idx]    <= disp.dest;
				rob_idx[free_idx] <= disp.rob_idx;
				for (int j = 0; j < N; j++) begin
					older[free_idx][j] <= 1'b0; // newest entry
					if (IW'(j) != free_idx)
						older[j][free_idx] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/func_units.sv
// the multiplier always owns the bus; a held adder result can wait behind it indefinitely
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module func_units (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              add_issue,
	input  logic              mul_issue,
	input  ooo_pkg::fu_func_t issue_func,
	input  ooo_pkg::value_t   issue_opa,
	input  ooo_pkg::value_t   issue_opb,
	input  ooo_pkg::prn_t     issue_dest,
	input  ooo_pkg::rob_idx_t issue_rob_idx,
	output logic              add_busy,
	cdb_if.source             cdb
);
	localparam int S = `OOO_MUL_STAGES;

	logic              add_vld;  // hold register full
	ooo_pkg::value_t   add_val;
	ooo_pkg::prn_t     add_dest;
	ooo_pkg::rob_idx_t add_rob;
	logic              add_grant;
	ooo_pkg::value_t   add_sum;

	logic [S-1:0]      mul_vld;
	ooo_pkg::value_t   mul_val  [S];
	logic [31:0]       mul_cross; // low half of the cross products
	ooo_pkg::prn_t     mul_dest [S];
	ooo_pkg::rob_idx_t mul_rob  [S];

	//////////////////////////////////////////////////
	// adder with hold register

	assign add_sum   = (issue_func == ooo_pkg::ALU_SUB) ? issue_opa - issue_opb :
		issue_opa + issue_opb;
	assign add_grant = add_vld && !mul_vld[S-1];
	assign add_busy  = add_vld && !add_grant; // a granted result frees the adder now

	always_ff @(posedge clock) begin
		if (!rst_n)
			add_vld <= 1'b0;
		else
			add_vld <= add_issue || (add_vld && !add_grant);
	end

	always_ff @(posedge clock) begin
		if (add_issue) begin
			add_val  <= add_sum;
			add_dest <= issue_dest;
			add_rob  <= issue_rob_idx;
		end
	end

	//////////////////////////////////////////////////
	// multiplier, split 32 bit products then sum

	always_ff @(posedge clock) begin
		if (!rst_n)
			mul_vld <= '0;
		else
			mul_vld <= {mul_vld[S-2:0], mul_issue};
	end

	always_ff @(posedge clock) begin
		mul_val[0]  <= {32'b0, issue_opa[31:0]} * {32'b0, issue_opb[31:0]};
		mul_cross   <= issue_opa[31:0] * issue_opb[63:32] + issue_opa[63:32] * issue_opb[31:0];
		mul_dest[0] <= issue_dest;
		mul_rob[0]  <= issue_rob_idx;
		mul_val[1]  <= mul_val[0] + {mul_cross, 32'b0}; // high products drop out
		for (int s = 2; s < S; s++) begin
			mul_val[s] <= mul_val[s-1];
		end
		for (int s = 1; s < S; s++) begin
			mul_dest[s] <= mul_dest[s-1];
			mul_rob[s]  <= mul_rob[s-1];
		end
	end

	//////////////////////////////////////////////////
	// bus arbitration

	assign cdb.valid   = mul_vld[S-1] || add_vld;
	assign cdb.tag     = mul_vld[S-1] ? mul_dest[S-1] : add_dest;
	assign cdb.value   = mul_vld[S-1] ? mul_val[S-1]  : add_val;
	assign cdb.rob_idx = mul_vld[S-1] ? mul_rob[S-1]  : add_rob;

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
// commits one done head per cycle in program order; there is no flush
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module reorder_buffer (
	input  logic            clock,
	input  logic            rst_n,
	rob_alloc_if.sink       alloc,
	cdb_if.listener         cdb,
	output logic            free_valid,   // old_prn back to the free list
	output ooo_pkg::prn_t   free_prn,
	output logic            commit_valid,
	output ooo_pkg::arn_t   commit_arn,
	output logic            commit_wr_en, // low for the zero register
	output ooo_pkg::value_t commit_value
);
	localparam int N  = `OOO_ROB_SIZE;
	localparam int IW = $clog2(N);

	ooo_pkg::arn_t     arn     [N];
	logic [N-1:0]      has_dest;
	ooo_pkg::prn_t     old_prn [N];
	ooo_pkg::value_t   value   [N];
	logic [N-1:0]      done;
	ooo_pkg::rob_idx_t head;
	ooo_pkg::rob_idx_t tail;
	logic [IW:0]       count;

	//////////////////////////////////////////////////
	// head commit and allocation status

	assign commit_valid = (count != '0) && done[head]; // cycle after the result lands
	assign commit_arn   = arn[head];
	assign commit_wr_en = has_dest[head];
	assign commit_value = value[head];
	assign free_valid   = commit_valid && has_dest[head];
	assign free_prn     = old_prn[head];

	assign alloc.tail_idx = tail;
	assign alloc.full     = count == (IW+1)'(N);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (cdb.valid)
				done[cdb.rob_idx] <= 1'b1;
			if (alloc.valid) begin
				done[tail] <= 1'b0; // cleared again for reuse
				tail       <= tail + IW'(1);
			end
			if (commit_valid)
				head <= head + IW'(1);
			count <= count + (IW+1)'(alloc.valid) - (IW+1)'(commit_valid);
		end
	end

	//////////////////////////////////////////////////
	// entry payload

	always_ff @(posedge clock) begin
		if (cdb.valid)
			value[cdb.rob_idx] <= cdb.value;
		if (alloc.valid) begin
			arn[tail]      <= alloc.arn;
			has_dest[tail] <= alloc.has_dest;
			old_prn[tail]  <= alloc.old_prn;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ooo_core.sv
// the source must hold inst and inst_valid steady while stall is high
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module ooo_core (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	output logic            stall,
	output logic            commit_valid,
	output ooo_pkg::arn_t   commit_arn,
	output logic            commit_wr_en,
	output ooo_pkg::value_t commit_value
);
	cdb_if       cdb ();   // single result bus
	dispatch_if  disp ();  // rename to reservation station
	rob_alloc_if alloc (); // rename to reorder buffer

	logic              free_valid;
	ooo_pkg::prn_t     free_prn;
	logic              add_busy;
	logic              add_issue;
	logic              mul_issue;
	ooo_pkg::fu_func_t issue_func;
	ooo_pkg::value_t   issue_opa;
	ooo_pkg::value_t   issue_opb;
	ooo_pkg::prn_t     issue_dest;
	ooo_pkg::rob_idx_t issue_rob_idx;

	// decode
	rename_stage u_rename (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.stall      (stall),
		.cdb        (cdb.listener),
		.disp       (disp.source),
		.alloc      (alloc.source),
		.free_valid (free_valid),
		.free_prn   (free_prn)
	);

	// execute
	issue_queue u_issue (
		.clock         (clock),
		.rst_n         (rst_n),
		.disp          (disp.sink),
		.cdb           (cdb.listener),
		.add_busy      (add_busy),
		.add_issue     (add_issue),
		.mul_issue     (mul_issue),
		.issue_func    (issue_func),
		.issue_opa     (issue_opa),
		.issue_opb     (issue_opb),
		.issue_dest    (issue_dest),
		.issue_rob_idx (issue_rob_idx)
	);

	func_units u_fu (
		.clock         (clock),
		.rst_n         (rst_n),
		.add_issue     (add_issue),
		.mul_issue     (mul_issue),
		.issue_func    (issue_func),
		.issue_opa     (issue_opa),
		.issue_opb     (issue_opb),
		.issue_dest    (issue_dest),
		.issue_rob_idx (issue_rob_idx),
		.add_busy      (add_busy),
		.cdb           (cdb.source)
	);

	// result
	reorder_buffer u_rob (
		.clock        (clock),
		.rst_n        (rst_n),
		.alloc        (alloc.sink),
		.cdb          (cdb.listener),
		.free_valid   (free_valid),
		.free_prn     (free_prn),
		.commit_valid (commit_valid),
		.commit_arn   (commit_arn),
		.commit_wr_en (commit_wr_en),
		.commit_value (commit_value)
	);

endmodule

`default_nettype wire

//--- sim/ooo_tb_clock.sv
// free running clock that starts low at time zero; the period is fixed and not adjustable
`timescale 1ns/1ps
`default_nettype none

module ooo_tb_clock (
	output logic clock
);
	localparam realtime HALF_PERIOD = 5ns; // 10 ns period

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

endmodule

`default_nettype wire

//--- sim/ooo_tb.sv
// drives ooo_core from one source that holds while stall is high; model assumes in order commit
`timescale 1ns/1ps
`default_nettype none
`include "ooo_config.svh"

module ooo_tb;
	localparam int N_DIRECTED  = 30;  // chain, addi, mul mix, zero reg
	localparam int N_RANDOM    = 400;
	localparam int CYCLE_LIMIT = 20 * (N_DIRECTED + N_RANDOM) + 200;
	localparam int DRAIN_LIMIT = 200; // cycles for a full window to retire

	typedef struct packed {
		logic            known; // opcode is one the core executes
		ooo_pkg::arn_t   arn;
		logic            wr_en;
		ooo_pkg::value_t value;
	} expect_t;

	logic            clock;
	logic            rst_n;
	logic            inst_valid;
	logic [31:0]     inst;
	logic            stall;
	logic            commit_valid;
	ooo_pkg::arn_t   commit_arn;
	logic            commit_wr_en;
	ooo_pkg::value_t commit_value;

	ooo_pkg::value_t model_rf [`OOO_ARF_SIZE]; // architectural state that starts all zero
	expect_t         exp_q [$];                // accepted but not yet committed
	integer          seed;
	int              cycle = 0;
	int              mismatch_errors = 0;
	int              other_errors = 0;
	int              n_accepted = 0; // valid opcodes only
	int              n_commits = 0;
	int              stall_cycles = 0;

	ooo_tb_clock u_clock (
		.clock (clock)
	);

	ooo_core u_dut (
		.clock        (clock),
		.rst_n        (rst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.stall        (stall),
		.commit_valid (commit_valid),
		.commit_arn   (commit_arn),
		.commit_wr_en (commit_wr_en),
		.commit_value (commit_value)
	);

	//////////////////////////////////////////////////
	// encoding and reference model

	function automatic logic [31:0] enc_reg(input logic [5:0] op, input int d, input int a,
		input int b);
		ooo_pkg::reg_fmt_t f;
		f.opcode = op;
		f.dest   = ooo_pkg::arn_t'(d);
		f.srca   = ooo_pkg::arn_t'(a);
		f.srcb   = ooo_pkg::arn_t'(b);
		f.unused = '0;
		return f;
	endfunction

	function automatic logic [31:0] enc_imm(input int d, input int a, input logic [15:0] imm);
		ooo_pkg::imm_fmt_t f;
		f.opcode = ooo_pkg::OP_ADDI;
		f.dest   = ooo_pkg::arn_t'(d);
		f.srca   = ooo_pkg::arn_t'(a);
		f.imm    = imm;
		return f;
	endfunction

	function automatic expect_t ref_exec(input ooo_pkg::inst_word_u w);
		expect_t         e;
		ooo_pkg::value_t a;
		ooo_pkg::value_t b;
		ooo_pkg::value_t imm;
		a       = model_rf[w.r.srca]; // register 31 is never written, so it reads 0
		b       = model_rf[w.r.srcb];
		imm     = 64'($signed(w.i.imm));
		e.known = 1'b1;
		e.arn   = w.r.dest;
		e.wr_en = w.r.dest != ooo_pkg::arn_t'(`OOO_ZERO_REG);
		case (w.r.opcode)
			ooo_pkg::OP_ADD:  e.value = a + b;
			ooo_pkg::OP_SUB:  e.value = a - b;
			ooo_pkg::OP_MUL:  e.value = a * b; // truncated to 64 bits
			ooo_pkg::OP_ADDI: e.value = a + imm;
			default: begin
				e.known = 1'b0; // dropped by the core
				e.value = '0;
			end
		endcase
		return e;
	endfunction

	task automatic record_accept(input logic [31:0] w);
		expect_t e;
		e = ref_exec(w);
		if (e.known) begin
			exp_q.push_back(e);
			n_accepted++;
			if (e.wr_en)
				model_rf[e.arn] = e.value;
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus

	task automatic send_inst(input logic [31:0] w);
		@(negedge clock);
		inst       <= w;
		inst_valid <= 1'b1;
		@(posedge clock);
		while (stall) begin
			stall_cycles++; // held until taken
			@(posedge clock);
		end
		record_accept(w);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clock);
			inst_valid <= 1'b0;
		end
	endtask

	function automatic int pick_reg();
		int x;
		x = int'({$random(seed)} % 10);
		if (x < 8)
			return x; // small set gives lots of dependencies
		if (x == 8)
			return `OOO_ZERO_REG;
		return int'({$random(seed)} % 32);
	endfunction

	task automatic add_sub_chain();
		send_inst(enc_imm(1, 0, 16'd7));
		send_inst(enc_imm(2, 0, 16'd3));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 3, 1, 2));
		send_inst(enc_reg(ooo_pkg::OP_SUB, 4, 3, 1));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 5, 4, 3));
		send_inst(enc_reg(ooo_pkg::OP_SUB, 6, 2, 5)); // goes negative
		send_inst(enc_reg(ooo_pkg::OP_ADD, 6, 6, 6));
		send_inst(enc_reg(ooo_pkg::OP_SUB, 7, 6, 6));
	endtask

	task automatic addi_sign_extend();
		send_inst(enc_imm(8, 0, 16'hFFFF));  // -1
		send_inst(enc_imm(9, 1, 16'h8000));  // most negative
		send_inst(enc_imm(10, 8, 16'h7FFF)); // most positive
		send_inst(enc_imm(10, 10, 16'hFF00));
	endtask

	task automatic mul_add_mix();
		send_inst(enc_reg(ooo_pkg::OP_MUL, 11, 3, 5));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 12, 1, 2)); // independent so it may finish first
		send_inst(enc_reg(ooo_pkg::OP_MUL, 13, 11, 11));
		send_inst(enc_reg(ooo_pkg::OP_SUB, 14, 2, 1));
		send_inst(enc_reg(ooo_pkg::OP_MUL, 15, 8, 9));
		send_inst(enc_imm(16, 14, 16'd1));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 17, 13, 15));
		send_inst(enc_reg(ooo_pkg::OP_MUL, 18, 13, 13));
		send_inst(enc_reg(ooo_pkg::OP_MUL, 18, 18, 18));
		send_inst(enc_reg(ooo_pkg::OP_MUL, 18, 18, 18)); // wraps past 64 bits
	endtask

	task automatic zero_reg_and_bad_ops();
		send_inst(enc_imm(`OOO_ZERO_REG, 1, 16'd100));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 19, `OOO_ZERO_REG, 1));
		send_inst(enc_reg(ooo_pkg::OP_MUL, `OOO_ZERO_REG, 3, 3));
		send_inst(enc_reg(ooo_pkg::OP_SUB, 20, 2, `OOO_ZERO_REG));
		send_inst(enc_reg(6'h3F, 21, 1, 1)); // unknown opcode never commits
		send_inst(enc_reg(6'h00, 1, 2, 2));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 22, 21, 1));
		send_inst(enc_reg(ooo_pkg::OP_ADD, 23, 1, 0)); // r1 must be untouched
	endtask

	task automatic random_stream();
		int         r;
		logic [5:0] op;
		for (int k = 0; k < N_RANDOM; k++) begin
			r = int'({$random(seed)} % 20);
			if (r < 8)
				op = ooo_pkg::OP_MUL; // mul heavy to fill the window
			else if (r < 12)
				op = ooo_pkg::OP_ADD;
			else if (r < 15)
				op = ooo_pkg::OP_SUB;
			else if (r < 19)
				op = ooo_pkg::OP_ADDI;
			else
				op = 6'h3F;
			if (op == ooo_pkg::OP_ADDI)
				send_inst(enc_imm(pick_reg(), pick_reg(), 16'($random(seed))));
			else
				send_inst(enc_reg(op, pick_reg(), pick_reg(), pick_reg()));
		end
	endtask

	//////////////////////////////////////////////////
	// checking

	task automatic check_arn(input ooo_pkg::arn_t exp, input ooo_pkg::arn_t act);
		if (exp !== act) begin
			$display("Fail %0t commit_arn expected %0d actual %0d", $time, exp, act);
			mismatch_errors++;
		end
	endtask

	task automatic check_wr_en(input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %0t commit_wr_en expected %0b actual %0b", $time, exp, act);
			mismatch_errors++;
		end
	endtask

	task automatic check_value(input ooo_pkg::value_t exp, input ooo_pkg::value_t act);
		if (exp !== act) begin
			$display("Fail %0t commit_value expected %016h actual %016h", $time, exp, act);
			mismatch_errors++;
		end
	endtask

	task automatic check_stall(input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %0t stall expected %0b actual %0b", $time, exp, act);
			mismatch_errors++;
		end
	endtask

	// commit outputs come from ROB registers only, so they are settled at the falling edge
	always @(negedge clock) begin : compare_commits
		expect_t e;
		if (rst_n && commit_valid) begin
			n_commits++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t: commit of r%0d with nothing outstanding", $time,
					commit_arn);
				other_errors++;
			end else begin
				e = exp_q.pop_front();
				check_arn(e.arn, commit_arn);
				check_wr_en(e.wr_en, commit_wr_en);
				if (e.wr_en)
					check_value(e.value, commit_value); // value unspecified for r31
			end
		end
	end

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other; %0d commits for %0d valid instructions",
			mismatch_errors, other_errors, n_commits, n_accepted);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	always @(posedge clock) begin : watchdog
		cycle++;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d commits still expected", cycle,
				exp_q.size());
			other_errors++;
			finish_run();
		end
	end

	initial begin : main
		seed       = 32;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		for (int i = 0; i < `OOO_ARF_SIZE; i++) begin
			model_rf[i] = '0;
		end
		repeat (10) @(negedge clock);
		check_stall(1'b0, stall); // empty window after reset
		rst_n <= 1'b1;
		add_sub_chain();
		addi_sign_extend();
		mul_add_mix();
		zero_reg_and_bad_ops();
		random_stream();
		idle_cycles(1);
		for (int k = 0; k < DRAIN_LIMIT && exp_q.size() != 0; k++) begin
			@(negedge clock);
		end
		idle_cycles(20); // window for stray commits
		if (exp_q.size() != 0) begin
			$display("Error: %0d instructions never committed", exp_q.size());
			other_errors++;
		end
		if (n_commits != n_accepted) begin
			$display("Error: %0d commits for %0d accepted instructions", n_commits, n_accepted);
			other_errors++;
		end
		if (stall_cycles == 0) begin
			$display("Error: stall never went high during the run");
			other_errors++;
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/ooo_pkg.sv
verilog/ooo_if.sv
verilog/rename_stage.sv
verilog/issue_queue.sv
verilog/func_units.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
sim/ooo_tb_clock.sv
sim/ooo_tb.sv

//--- Makefile
TOOL       = verilator
TOP        = ooo_tb
FLIST      = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
PASS_MSG   = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass or fail is decided by the log, not by the exit code of the run
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
